//--- sim.f
hw/perm_pkg.sv
hw/vec_stream_if.sv
hw/perm_ctrl.sv
hw/vec_source_bank.sv
hw/switch_config.sv
hw/benes_stage.sv
hw/benes_network.sv
hw/vec_capture_bank.sv
hw/perm_top.sv
testbench/tb_perm_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the permutation engine testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -j 0 \
    --top-module tb_perm_top \
    -f sim.f \
    -o tb_perm_top

./obj_dir/tb_perm_top > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "run_sim.sh: testbench reported a failure, see sim.log"
    exit 1
fi
echo "run_sim.sh: no failure found in sim.log"

//--- testbench/perm_testdata.txt
# record header: switch rows for stages 0 to 4 in hex, then the test name
# vector line: input lanes 0 to 7, then expected output lanes 0 to 7, all hex
0 0 0 0 0 all_bar
c000 c001 c002 c003 c004 c005 c006 c007 c000 c001 c002 c003 c004 c005 c006 c007
c010 c011 c012 c013 c014 c015 c016 c017 c010 c011 c012 c013 c014 c015 c016 c017
c020 c021 c022 c023 c024 c025 c026 c027 c020 c021 c022 c023 c024 c025 c026 c027
c030 c031 c032 c033 c034 c035 c036 c037 c030 c031 c032 c033 c034 c035 c036 c037

f f f f f all_cross
d100 d101 d102 d103 d104 d105 d106 d107 d104 d105 d106 d107 d100 d101 d102 d103
d110 d111 d112 d113 d114 d115 d116 d117 d114 d115 d116 d117 d110 d111 d112 d113
d120 d121 d122 d123 d124 d125 d126 d127 d124 d125 d126 d127 d120 d121 d122 d123
d130 d131 d132 d133 d134 d135 d136 d137 d134 d135 d136 d137 d130 d131 d132 d133

1 0 0 0 0 single_bit
e200 e201 e202 e203 e204 e205 e206 e207 e201 e200 e202 e203 e204 e205 e206 e207
e210 e211 e212 e213 e214 e215 e216 e217 e211 e210 e212 e213 e214 e215 e216 e217
e220 e221 e222 e223 e224 e225 e226 e227 e221 e220 e222 e223 e224 e225 e226 e227
e230 e231 e232 e233 e234 e235 e236 e237 e231 e230 e232 e233 e234 e235 e236 e237

5 a 3 c 6 mixed
f300 f301 f302 f303 f304 f305 f306 f307 f306 f303 f300 f305 f304 f301 f302 f307
f310 f311 f312 f313 f314 f315 f316 f317 f316 f313 f310 f315 f314 f311 f312 f317
f320 f321 f322 f323 f324 f325 f326 f327 f326 f323 f320 f325 f324 f321 f322 f327
f330 f331 f332 f333 f334 f335 f336 f337 f336 f333 f330 f335 f334 f331 f332 f337

//--- testbench/tb_perm_top.sv
`timescale 1ns/1ps

module tb_perm_top;

    localparam string       DATA_FILE   = "testbench/perm_testdata.txt";
    localparam logic [31:0] SEED        = 32'hf70e_4088;
    localparam int          ACK_TIMEOUT = 50;      // clock cycles per bus access
    localparam int          RUN_TIMEOUT = 100;     // status reads per run
    localparam int          REC_NUM     = 4;
    localparam logic [7:0]  UNMAPPED    = 8'h80;

    logic        clk;
    logic        i_rst_n;
    logic        i_wb_cyc;
    logic        i_wb_stb;
    logic        i_wb_we;
    logic [7:0]  i_wb_adr;
    logic [31:0] i_wb_dat;
    logic [31:0] o_wb_dat;
    logic        o_wb_ack;

    int          pass_cnt;
    int          fail_cnt;
    int          err_cnt;                          // errors in the running test
    int          seed_val;
    logic        timed_out;

    logic [19:0]  rec_rows [REC_NUM];              // stage s in bits 4s+3..4s
    logic [127:0] rec_in   [REC_NUM][4];           // lane 0 in the low bits
    logic [127:0] rec_exp  [REC_NUM][4];
    string        rec_name [REC_NUM];

    perm_top uut (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // rotate the low n bits of a lane index by one place
    function automatic int rot_right(input int p, input int n);
        int mask;
        int low;
        mask = (1 << n) - 1;
        low  = p & mask;
        return (p & ~mask) | (low >> 1) | ((low & 1) << (n - 1));
    endfunction

    function automatic int rot_left(input int p, input int n);
        int mask;
        int low;
        mask = (1 << n) - 1;
        low  = p & mask;
        return (p & ~mask) | ((low << 1) & mask) | (low >> (n - 1));
    endfunction

    function automatic int stage_dest(input int s, input int p);
        case (s)
            0:       return rot_right(p, 3);
            1:       return rot_right(p, 2);
            2:       return rot_left(p, 2);
            3:       return rot_left(p, 3);
            default: return p;                     // output stage
        endcase
    endfunction

    // reference model of the five switch stages
    function automatic logic [127:0] model_perm(input logic [19:0] rows, input logic [127:0] vin);
        logic [127:0] cur;
        logic [127:0] nxt;
        int           src;
        cur = vin;
        nxt = '0;
        for (int s = 0; s < 5; s++) begin
            for (int p = 0; p < 8; p++) begin
                src = rows[s*4 + p/2] ? (p ^ 1) : p;   // crossed switch swaps the pair
                nxt[stage_dest(s, p)*16 +: 16] = cur[src*16 +: 16];
            end
            cur = nxt;
        end
        return cur;
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("MISMATCH %s expected 0x%h actual 0x%h", sig, exp, act);
        err_cnt++;
    endtask

    task automatic begin_test();
        err_cnt = 0;
    endtask

    task automatic end_test(input string name);
        if (err_cnt == 0) begin
            pass_cnt++;
            $display("PASS %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL %s with %0d errors", name, err_cnt);
        end
    endtask

    task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int   waited;
        logic acked;
        waited = 0;
        acked  = 1'b0;
        rdat   = '0;
        if (!timed_out) begin
            @(posedge clk);
            i_wb_cyc <= 1'b1;
            i_wb_stb <= 1'b1;
            i_wb_we  <= we;
            i_wb_adr <= adr;
            i_wb_dat <= wdat;
            while (!acked && waited < ACK_TIMEOUT) begin
                @(negedge clk);                    // ack and data settled here
                waited++;
                if (o_wb_ack) begin
                    acked = 1'b1;
                    rdat  = o_wb_dat;
                end
            end
            @(posedge clk);
            i_wb_cyc <= 1'b0;
            i_wb_stb <= 1'b0;
            i_wb_we  <= 1'b0;
            if (!acked) begin
                $display("ERROR: no ack within %0d cycles for address 0x%h", ACK_TIMEOUT, adr);
                err_cnt++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic bus_write(input logic [7:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic bus_read(input logic [7:0] adr, output logic [31:0] dat);
        bus_cycle(1'b0, adr, 32'h0, dat);
    endtask

    task automatic read_records();
        int          fd;
        int          rec;
        int          pos;
        int          n;
        string       line;
        string       name;
        logic [3:0]  rw [5];
        logic [15:0] v [16];
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open data file %s", DATA_FILE);
            fail_cnt++;
            return;
        end
        rec = 0;
        pos = 0;
        while (rec < REC_NUM && $fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == 8'h23) begin
                continue;                          // blank or comment line
            end
            if (pos == 0) begin
                n = $sscanf(line, "%h %h %h %h %h %s", rw[0], rw[1], rw[2], rw[3], rw[4], name);
                for (int s = 0; s < 5; s++) begin
                    rec_rows[rec][s*4 +: 4] = rw[s];
                end
                rec_name[rec] = name;
            end else begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                            v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15]);
                for (int l = 0; l < 8; l++) begin
                    rec_in[rec][pos-1][l*16 +: 16]  = v[l];
                    rec_exp[rec][pos-1][l*16 +: 16] = v[l+8];
                end
            end
            if ((pos == 0 && n != 6) || (pos != 0 && n != 16)) begin
                $display("ERROR: data file line not understood: %s", line);
                fail_cnt++;
            end
            pos++;
            if (pos == 5) begin
                pos = 0;
                rec++;
            end
        end
        $fclose(fd);
        if (rec != REC_NUM) begin
            $display("ERROR: data file holds %0d complete records instead of %0d", rec, REC_NUM);
            fail_cnt++;
        end
    endtask

    task automatic wait_run_done();
        logic [31:0] st;
        int          polls;
        st    = '0;
        polls = 0;
        while (st !== 32'h2 && polls < RUN_TIMEOUT && !timed_out) begin
            bus_read(perm_pkg::CTRL_ADR, st);      // done 1, busy 0
            polls++;
        end
        if (st !== 32'h2 && !timed_out) begin
            $display("ERROR: run not finished after %0d status reads", polls);
            err_cnt++;
            timed_out = 1'b1;
        end
    endtask

    task automatic load_record(input int r);
        for (int i = 0; i < 32; i++) begin
            bus_write(perm_pkg::IN_BASE + 8'(i), {16'h0, rec_in[r][i/8][(i%8)*16 +: 16]});
        end
        for (int s = 0; s < 5; s++) begin
            bus_write(perm_pkg::SW_BASE + 8'(s), {28'h0, rec_rows[r][s*4 +: 4]});
        end
    endtask

    task automatic compare_outputs(input int r);
        logic [31:0] rd;
        logic [31:0] exp;
        for (int i = 0; i < 32; i++) begin
            bus_read(perm_pkg::OUT_BASE + 8'(i), rd);
            exp = {16'h0, rec_exp[r][i/8][(i%8)*16 +: 16]};
            if (rd !== exp) report_mismatch($sformatf("o_wb_dat out[%0d]", i), exp, rd);
        end
    endtask

    task automatic after_reset_status();
        logic [31:0] rd;
        begin_test();
        bus_read(perm_pkg::CTRL_ADR, rd);
        if (rd !== 32'h0) report_mismatch("o_wb_dat status", 32'h0, rd);
        bus_read(UNMAPPED, rd);
        if (rd !== 32'h0) report_mismatch("o_wb_dat unmapped", 32'h0, rd);
        end_test("reset_status");
    endtask

    task automatic lane_readback();
        logic [31:0] wr [32];
        logic [31:0] sw [5];
        logic [31:0] rd;
        begin_test();
        for (int i = 0; i < 32; i++) begin
            wr[i] = $urandom();
            bus_write(perm_pkg::IN_BASE + 8'(i), wr[i]);
        end
        for (int i = 0; i < 32; i++) begin
            bus_read(perm_pkg::IN_BASE + 8'(i), rd);
            if (rd !== {16'h0, wr[i][15:0]}) begin
                report_mismatch($sformatf("o_wb_dat in[%0d]", i), {16'h0, wr[i][15:0]}, rd);
            end
        end
        for (int s = 0; s < 5; s++) begin
            sw[s] = $urandom();
            bus_write(perm_pkg::SW_BASE + 8'(s), sw[s]);
        end
        for (int s = 0; s < 5; s++) begin
            bus_read(perm_pkg::SW_BASE + 8'(s), rd);
            if (rd !== {28'h0, sw[s][3:0]}) begin
                report_mismatch($sformatf("o_wb_dat row[%0d]", s), {28'h0, sw[s][3:0]}, rd);
            end
        end
        end_test("readback");
    endtask

    task automatic record_run(input int r);
        begin_test();
        for (int v = 0; v < 4; v++) begin
            if (model_perm(rec_rows[r], rec_in[r][v]) !== rec_exp[r][v]) begin
                $display("ERROR: data file record %0d vector %0d disagrees with the model", r, v);
                err_cnt++;
            end
        end
        load_record(r);
        bus_write(perm_pkg::CTRL_ADR, 32'h1);
        wait_run_done();
        compare_outputs(r);
        end_test(rec_name[r]);
    endtask

    task automatic busy_guard(input int r);
        logic [31:0] rd;
        logic [3:0]  old_row;
        begin_test();
        load_record(r);
        old_row = rec_rows[r][3:0];
        bus_write(perm_pkg::CTRL_ADR, 32'h1);
        bus_read(perm_pkg::CTRL_ADR, rd);
        if (rd !== 32'h1) report_mismatch("o_wb_dat status", 32'h1, rd);
        bus_write(perm_pkg::CTRL_ADR, 32'h1);      // second start during the run
        bus_write(perm_pkg::SW_BASE, {28'h0, ~old_row});
        wait_run_done();
        compare_outputs(r);
        bus_read(perm_pkg::SW_BASE, rd);
        if (rd !== {28'h0, old_row}) report_mismatch("o_wb_dat row[0]", {28'h0, old_row}, rd);
        end_test("busy_guard");
    endtask

    initial begin
        i_rst_n   = 1'b0;
        i_wb_cyc  = 1'b0;
        i_wb_stb  = 1'b0;
        i_wb_we   = 1'b0;
        i_wb_adr  = '0;
        i_wb_dat  = '0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        err_cnt   = 0;
        timed_out = 1'b0;
        seed_val  = $urandom(SEED);
        read_records();
        repeat (8) @(posedge clk);
        i_rst_n <= 1'b1;

        if (!timed_out) after_reset_status();
        if (!timed_out) lane_readback();
        for (int r = 0; r < REC_NUM; r++) begin
            if (!timed_out) record_run(r);
        end
        if (!timed_out) busy_guard(0);             // capture bank still holds the last record

        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- hw/perm_top.sv
`timescale 1ns/1ps

module perm_top (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic                       i_wb_cyc,
    input  logic                       i_wb_stb,
    input  logic                       i_wb_we,
    input  logic [perm_pkg::ADR_W-1:0] i_wb_adr,
    input  logic [perm_pkg::WB_W-1:0]  i_wb_dat,
    output logic [perm_pkg::WB_W-1:0]  o_wb_dat,
    output logic                       o_wb_ack
);

    logic                                                src_we;
    logic [perm_pkg::LANE_IDX_W-1:0]                     src_idx;
    logic [perm_pkg::LANE_W-1:0]                         src_wdata;
    logic [perm_pkg::LANE_W-1:0]                         src_rdata;
    logic                                                sw_we;
    logic [perm_pkg::STAGE_SEL_W-1:0]                    sw_stage;
    logic [perm_pkg::SWITCH_NUM-1:0]                     sw_wrow;
    logic [perm_pkg::SWITCH_NUM-1:0]                     sw_rdata;
    logic [perm_pkg::STAGE_NUM*perm_pkg::SWITCH_NUM-1:0] sw_rows;
    logic [perm_pkg::LANE_IDX_W-1:0]                     cap_idx;
    logic [perm_pkg::LANE_W-1:0]                         cap_rdata;
    logic                                                capture_last;
    logic                                                issue_go;
    logic [perm_pkg::TAG_W-1:0]                          issue_idx;

    vec_stream_if s_issue ();
    vec_stream_if s_result ();

    perm_ctrl u_ctrl (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_wb_cyc       (i_wb_cyc),
        .i_wb_stb       (i_wb_stb),
        .i_wb_we        (i_wb_we),
        .i_wb_adr       (i_wb_adr),
        .i_wb_dat       (i_wb_dat),
        .i_src_rdata    (src_rdata),
        .i_sw_rdata     (sw_rdata),
        .i_cap_rdata    (cap_rdata),
        .i_capture_last (capture_last),
        .o_wb_dat       (o_wb_dat),
        .o_wb_ack       (o_wb_ack),
        .o_src_we       (src_we),
        .o_src_idx      (src_idx),
        .o_src_wdata    (src_wdata),
        .o_sw_we        (sw_we),
        .o_sw_stage     (sw_stage),
        .o_sw_wrow      (sw_wrow),
        .o_cap_idx      (cap_idx),
        .o_issue_go     (issue_go),
        .o_issue_idx    (issue_idx),
        .o_busy         ()
    );

    vec_source_bank u_src (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_we        (src_we),
        .i_widx      (src_idx),
        .i_wdata     (src_wdata),
        .i_ridx      (src_idx),                    // same word address as the write
        .i_issue_go  (issue_go),
        .i_issue_idx (issue_idx),
        .o_rdata     (src_rdata),
        .o_issue     (s_issue.source)
    );

    switch_config u_swcfg (
        .clk      (clk),
        .i_we     (sw_we),
        .i_stage  (sw_stage),
        .i_wrow   (sw_wrow),
        .i_rstage (sw_stage),
        .o_rdata  (sw_rdata),
        .o_rows   (sw_rows)
    );

    benes_network u_net (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_rows   (sw_rows),
        .i_issue  (s_issue.sink),
        .o_result (s_result.source)
    );

    vec_capture_bank u_cap (
        .clk            (clk),
        .i_ridx         (cap_idx),
        .i_result       (s_result.sink),
        .o_rdata        (cap_rdata),
        .o_capture_last (capture_last)
    );

endmodule

//--- hw/vec_capture_bank.sv
`timescale 1ns/1ps

module vec_capture_bank (
    input  logic                            clk,
    input  logic [perm_pkg::LANE_IDX_W-1:0] i_ridx,
    vec_stream_if.sink                      i_result,
    output logic [perm_pkg::LANE_W-1:0]     o_rdata,
    output logic                            o_capture_last
);

    logic [perm_pkg::VEC_W-1:0]         vecs [perm_pkg::VEC_NUM];
    logic [perm_pkg::TAG_W-1:0]         rd_vec;
    logic [perm_pkg::LANE_SEL_W-1:0]    rd_lane;
    logic [perm_pkg::VEC_W-1:0]         rd_word;

    always_ff @(posedge clk) begin
        if (i_result.valid) begin
            vecs[i_result.tag] <= i_result.data; // stored at its tag
        end
    end

    // rises on the edge that stores the last vector
    always_ff @(posedge clk) begin
        o_capture_last <= i_result.valid & i_result.last;
    end

    assign rd_vec  = i_ridx[perm_pkg::LANE_IDX_W-1:perm_pkg::LANE_SEL_W];
    assign rd_lane = i_ridx[perm_pkg::LANE_SEL_W-1:0];
    assign rd_word = vecs[rd_vec];
    assign o_rdata = rd_word[rd_lane*perm_pkg::LANE_W +: perm_pkg::LANE_W];

endmodule

//--- hw/benes_network.sv
`timescale 1ns/1ps

module benes_network (
    input  logic                                                clk,
    input  logic                                                i_rst_n,
    input  logic [perm_pkg::STAGE_NUM*perm_pkg::SWITCH_NUM-1:0] i_rows,
    vec_stream_if.sink                                          i_issue,
    vec_stream_if.source                                        o_result
);

    localparam int SN = perm_pkg::STAGE_NUM;

    // index s feeds stage s, index SN is the network output
    logic [SN:0]                valid_c;
    logic [SN:0]                last_c;
    logic [perm_pkg::TAG_W-1:0] tag_c  [SN+1];
    logic [perm_pkg::VEC_W-1:0] data_c [SN+1];

    assign valid_c[0] = i_issue.valid;
    assign last_c[0]  = i_issue.last;
    assign tag_c[0]   = i_issue.tag;
    assign data_c[0]  = i_issue.data;

    for (genvar s = 0; s < SN; s++) begin : g_stage
        benes_stage #(
            .STAGE_IDX (s)
        ) u_stage (
            .clk     (clk),
            .i_rst_n (i_rst_n),
            .i_row   (i_rows[s*perm_pkg::SWITCH_NUM +: perm_pkg::SWITCH_NUM]),
            .i_valid (valid_c[s]),
            .i_tag   (tag_c[s]),
            .i_last  (last_c[s]),
            .i_data  (data_c[s]),
            .o_valid (valid_c[s+1]),
            .o_tag   (tag_c[s+1]),
            .o_last  (last_c[s+1]),
            .o_data  (data_c[s+1])
        );
    end

    assign o_result.valid = valid_c[SN];           // five cycles after issue
    assign o_result.last  = last_c[SN];
    assign o_result.tag   = tag_c[SN];
    assign o_result.data  = data_c[SN];

endmodule

//--- hw/benes_stage.sv
`timescale 1ns/1ps

module benes_stage #(
    parameter int STAGE_IDX = 0
) (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic [perm_pkg::SWITCH_NUM-1:0] i_row,
    input  logic                            i_valid,
    input  logic [perm_pkg::TAG_W-1:0]      i_tag,
    input  logic                            i_last,
    input  logic [perm_pkg::VEC_W-1:0]      i_data,
    output logic                            o_valid,
    output logic [perm_pkg::TAG_W-1:0]      o_tag,
    output logic                            o_last,
    output logic [perm_pkg::VEC_W-1:0]      o_data
);

    localparam int LW = perm_pkg::LANE_W;

    logic [perm_pkg::VEC_W-1:0] sw_data;
    logic [perm_pkg::VEC_W-1:0] wired_data;

    // lane p of the switch outputs lands on lane wire_dest(p)
    function automatic int wire_dest(input int p);
        logic [2:0] b;
        b = 3'(p);
        case (STAGE_IDX)
            0:       return int'({b[0], b[2:1]});      // low 3 bits right
            1, 2:    return int'({b[2], b[0], b[1]});  // low 2 bits, left equals right
            3:       return int'({b[1:0], b[2]});      // low 3 bits left
            default: return p;                         // last stage is unwired
        endcase
    endfunction

    always_comb begin
        for (int j = 0; j < perm_pkg::SWITCH_NUM; j++) begin
            if (i_row[j]) begin                    // cross
                sw_data[2*j*LW +: LW]     = i_data[(2*j+1)*LW +: LW];
                sw_data[(2*j+1)*LW +: LW] = i_data[2*j*LW +: LW];
            end else begin                         // bar
                sw_data[2*j*LW +: 2*LW] = i_data[2*j*LW +: 2*LW];
            end
        end
        for (int p = 0; p < perm_pkg::LANE_NUM; p++) begin
            wired_data[wire_dest(p)*LW +: LW] = sw_data[p*LW +: LW];
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        o_tag  <= i_tag;
        o_last <= i_last;
        o_data <= wired_data;
    end

endmodule

//--- hw/switch_config.sv
`timescale 1ns/1ps

module switch_config (
    input  logic                                            clk,
    input  logic                                            i_we,
    input  logic [perm_pkg::STAGE_SEL_W-1:0]                i_stage,
    input  logic [perm_pkg::SWITCH_NUM-1:0]                 i_wrow,
    input  logic [perm_pkg::STAGE_SEL_W-1:0]                i_rstage,
    output logic [perm_pkg::SWITCH_NUM-1:0]                 o_rdata,
    output logic [perm_pkg::STAGE_NUM*perm_pkg::SWITCH_NUM-1:0] o_rows
);

    logic [perm_pkg::SWITCH_NUM-1:0] rows [perm_pkg::STAGE_NUM];

    always_ff @(posedge clk) begin
        if (i_we) begin
            rows[i_stage] <= i_wrow;
        end
    end

    assign o_rdata = rows[i_rstage];

    // stage s owns bits s*4 .. s*4+3
    always_comb begin
        for (int s = 0; s < perm_pkg::STAGE_NUM; s++) begin
            o_rows[s*perm_pkg::SWITCH_NUM +: perm_pkg::SWITCH_NUM] = rows[s];
        end
    end

endmodule

//--- hw/vec_source_bank.sv
`timescale 1ns/1ps

module vec_source_bank (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic                            i_we,
    input  logic [perm_pkg::LANE_IDX_W-1:0] i_widx,
    input  logic [perm_pkg::LANE_W-1:0]     i_wdata,
    input  logic [perm_pkg::LANE_IDX_W-1:0] i_ridx,
    input  logic                            i_issue_go,
    input  logic [perm_pkg::TAG_W-1:0]      i_issue_idx,
    output logic [perm_pkg::LANE_W-1:0]     o_rdata,
    vec_stream_if.source                    o_issue
);

    logic [perm_pkg::LANE_W-1:0] lanes [perm_pkg::VEC_NUM * perm_pkg::LANE_NUM];
    logic [perm_pkg::VEC_W-1:0]  issue_vec;

    always_ff @(posedge clk) begin
        if (i_we) begin
            lanes[i_widx] <= i_wdata;
        end
    end

    assign o_rdata = lanes[i_ridx];                // host readback

    // gather the eight lanes of the selected vector
    always_comb begin
        for (int l = 0; l < perm_pkg::LANE_NUM; l++) begin
            issue_vec[l*perm_pkg::LANE_W +: perm_pkg::LANE_W] =
                lanes[int'(i_issue_idx) * perm_pkg::LANE_NUM + l];
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_issue.valid <= 1'b0;
        end else begin
            o_issue.valid <= i_issue_go;
        end
    end

    always_ff @(posedge clk) begin
        o_issue.tag  <= i_issue_idx;
        o_issue.last <= i_issue_idx == perm_pkg::LAST_TAG;
        o_issue.data <= issue_vec;
    end

endmodule

//--- hw/perm_ctrl.sv
`timescale 1ns/1ps

module perm_ctrl (
    input  logic                              clk,
    input  logic                              i_rst_n,
    input  logic                              i_wb_cyc,
    input  logic                              i_wb_stb,
    input  logic                              i_wb_we,
    input  logic [perm_pkg::ADR_W-1:0]        i_wb_adr,
    input  logic [perm_pkg::WB_W-1:0]         i_wb_dat,
    input  logic [perm_pkg::LANE_W-1:0]       i_src_rdata,
    input  logic [perm_pkg::SWITCH_NUM-1:0]   i_sw_rdata,
    input  logic [perm_pkg::LANE_W-1:0]       i_cap_rdata,
    input  logic                              i_capture_last,
    output logic [perm_pkg::WB_W-1:0]         o_wb_dat,
    output logic                              o_wb_ack,
    output logic                              o_src_we,
    output logic [perm_pkg::LANE_IDX_W-1:0]   o_src_idx,
    output logic [perm_pkg::LANE_W-1:0]       o_src_wdata,
    output logic                              o_sw_we,
    output logic [perm_pkg::STAGE_SEL_W-1:0]  o_sw_stage,
    output logic [perm_pkg::SWITCH_NUM-1:0]   o_sw_wrow,
    output logic [perm_pkg::LANE_IDX_W-1:0]   o_cap_idx,
    output logic                              o_issue_go,
    output logic [perm_pkg::TAG_W-1:0]        o_issue_idx,
    output logic                              o_busy
);

    logic [perm_pkg::ADR_W-1:0] in_off;
    logic [perm_pkg::ADR_W-1:0] out_off;
    logic [perm_pkg::ADR_W-1:0] sw_off;
    logic                       in_hit;
    logic                       out_hit;
    logic                       sw_hit;
    logic                       ctrl_hit;
    logic                       req;
    logic                       start_wr;
    logic                       busy;
    logic                       done;
    logic [1:0]                 state;
    logic [perm_pkg::TAG_W-1:0] issue_cnt;
    perm_pkg::wb_word_u         wr_word;
    perm_pkg::wb_word_u         rd_word;

    // region decode
    assign in_off   = i_wb_adr - perm_pkg::IN_BASE;
    assign out_off  = i_wb_adr - perm_pkg::OUT_BASE;
    assign sw_off   = i_wb_adr - perm_pkg::SW_BASE;
    assign in_hit   = in_off < perm_pkg::LANE_SPAN;
    assign out_hit  = out_off < perm_pkg::LANE_SPAN;
    assign sw_hit   = sw_off < perm_pkg::SW_SPAN;
    assign ctrl_hit = i_wb_adr == perm_pkg::CTRL_ADR;

    assign req      = i_wb_cyc & i_wb_stb & ~o_wb_ack; // new access, ack follows
    assign busy     = state != perm_pkg::ST_IDLE;
    assign start_wr = req & i_wb_we & ctrl_hit & i_wb_dat[0] & ~busy;
    assign wr_word  = i_wb_dat;

    // bank writes are dropped during a run
    assign o_src_we    = req & i_wb_we & in_hit & ~busy;
    assign o_src_idx   = in_off[perm_pkg::LANE_IDX_W-1:0];
    assign o_src_wdata = wr_word.lane_v.lane;
    assign o_sw_we     = req & i_wb_we & sw_hit & ~busy;
    assign o_sw_stage  = sw_off[perm_pkg::STAGE_SEL_W-1:0];
    assign o_sw_wrow   = wr_word.sw_v.row;
    assign o_cap_idx   = out_off[perm_pkg::LANE_IDX_W-1:0];

    assign o_issue_go  = state == perm_pkg::ST_ISSUE;
    assign o_issue_idx = issue_cnt;
    assign o_busy      = busy;

    always_comb begin
        rd_word = '0;                              // unmapped reads return zero
        if (in_hit) begin
            rd_word.lane_v.lane = i_src_rdata;
        end else if (out_hit) begin
            rd_word.lane_v.lane = i_cap_rdata;
        end else if (sw_hit) begin
            rd_word.sw_v.row = i_sw_rdata;
        end else if (ctrl_hit) begin
            rd_word[1:0] = {done, busy};
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= req;                       // one cycle per access
        end
    end

    always_ff @(posedge clk) begin
        o_wb_dat <= rd_word;                       // valid in the ack cycle
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state     <= perm_pkg::ST_IDLE;
            issue_cnt <= '0;
            done      <= 1'b0;
        end else begin
            case (state)
                perm_pkg::ST_IDLE: begin
                    if (start_wr) begin
                        state     <= perm_pkg::ST_ISSUE;
                        issue_cnt <= '0;
                        done      <= 1'b0;
                    end
                end
                perm_pkg::ST_ISSUE: begin
                    issue_cnt <= issue_cnt + 1'b1;
                    if (issue_cnt == perm_pkg::LAST_TAG) begin
                        state <= perm_pkg::ST_DRAIN;
                    end
                end
                perm_pkg::ST_DRAIN: begin
                    if (i_capture_last) begin  // last vector stored
                        state <= perm_pkg::ST_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= perm_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

//--- hw/vec_stream_if.sv
`timescale 1ns/1ps

interface vec_stream_if;

    logic                           valid;
    logic [perm_pkg::TAG_W-1:0]     tag;   // vector index within the run
    logic                           last;
    logic [perm_pkg::VEC_W-1:0]     data;  // lane 0 in the low bits

    // no back-pressure, the sink takes every valid cycle
    modport source (
        output valid, tag, last, data
    );

    modport sink (
        input valid, tag, last, data
    );

endinterface

//--- hw/perm_pkg.sv
package perm_pkg;

    localparam int LANE_W      = 16;
    localparam int LANE_NUM    = 8;
    localparam int SWITCH_NUM  = LANE_NUM / 2;
    localparam int STAGE_NUM   = 5;
    localparam int VEC_NUM     = 4;
    localparam int VEC_W       = LANE_NUM * LANE_W;
    localparam int ADR_W       = 8;
    localparam int WB_W        = 32;
    localparam int TAG_W       = 2;                // vector index width
    localparam int LANE_SEL_W  = 3;                // lane within a vector
    localparam int LANE_IDX_W  = 5;                // vector*8 + lane
    localparam int STAGE_SEL_W = 3;

    // word address map
    localparam logic [ADR_W-1:0] IN_BASE  = 8'h00;
    localparam logic [ADR_W-1:0] OUT_BASE = 8'h20;
    localparam logic [ADR_W-1:0] SW_BASE  = 8'h40;
    localparam logic [ADR_W-1:0] CTRL_ADR = 8'h48;
    localparam logic [ADR_W-1:0] LANE_SPAN = 8'd32; // size of the in and out regions
    localparam logic [ADR_W-1:0] SW_SPAN   = 8'd5;

    localparam logic [TAG_W-1:0] LAST_TAG = TAG_W'(VEC_NUM - 1);

    // run sequencer states
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_ISSUE = 2'd1;
    localparam logic [1:0] ST_DRAIN = 2'd2;

    typedef union packed {
        struct packed {
            logic [WB_W-LANE_W-1:0] zero;
            logic [LANE_W-1:0]      lane;
        } lane_v;                                  // input and output lane regions
        struct packed {
            logic [WB_W-SWITCH_NUM-1:0] zero;
            logic [SWITCH_NUM-1:0]      row;
        } sw_v;                                    // switch row region
    } wb_word_u;

endpackage
